// File: Bender.yml
package:
  name: fpu_lite

sources:
  - hw/fpu_lite_pkg.sv
  - hw/fpu_lite_issue.sv
  - hw/fpu_lite_regfile.sv
  - hw/fpu_lite_exec.sv
  - hw/fpu_lite_result.sv
  - hw/fpu_lite_top.sv
  - target: test
    files:
      - tests/fpu_lite_assert.sv
      - tests/fpu_lite_tb.sv

// File: fpu_lite.f
hw/fpu_lite_pkg.sv
hw/fpu_lite_issue.sv
hw/fpu_lite_regfile.sv
hw/fpu_lite_exec.sv
hw/fpu_lite_result.sv
hw/fpu_lite_top.sv
tests/fpu_lite_assert.sv
tests/fpu_lite_tb.sv

// File: hw/fpu_lite_exec.sv
/* execution stage: buffer pop, sign injection and moves,
   register file write and result load */

`timescale 1ns/1ps
`default_nettype none

module fpu_lite_exec (
  input  logic                    buf_valid_i,
  input  fpu_lite_pkg::op_t       buf_op_i,
  input  fpu_lite_pkg::reg_addr_t buf_rd_i,
  input  fpu_lite_pkg::reg_addr_t buf_rs1_i,
  input  fpu_lite_pkg::reg_addr_t buf_rs2_i,
  input  fpu_lite_pkg::xid_t      buf_id_i,
  input  fpu_lite_pkg::word_t     buf_int_op_i,
  input  logic                    res_free_i,
  input  fpu_lite_pkg::word_t     rf_rdata_a_i,
  input  fpu_lite_pkg::word_t     rf_rdata_b_i,
  output logic                    buf_pop_o,
  output fpu_lite_pkg::reg_addr_t rf_raddr_a_o,
  output fpu_lite_pkg::reg_addr_t rf_raddr_b_o,
  output logic                    rf_we_o,
  output fpu_lite_pkg::reg_addr_t rf_waddr_o,
  output fpu_lite_pkg::word_t     rf_wdata_o,
  output logic                    res_load_o,
  output fpu_lite_pkg::xid_t      res_id_o,
  output fpu_lite_pkg::reg_addr_t res_rd_o,
  output fpu_lite_pkg::word_t     res_data_o,
  output logic                    res_we_o
);

  logic                fire;
  logic                to_int;
  logic                sign;
  fpu_lite_pkg::word_t result;

  // one instruction per cycle when the result slot can take it
  assign fire      = buf_valid_i & res_free_i;
  assign buf_pop_o = fire;

  // operands straight from the register file
  assign rf_raddr_a_o = buf_rs1_i;
  assign rf_raddr_b_o = buf_rs2_i;

  // sign bit for the three injection variants
  always_comb begin
    case (buf_op_i)
      fpu_lite_pkg::OP_FSGNJN: sign = ~rf_rdata_b_i[31];
      fpu_lite_pkg::OP_FSGNJX: sign = rf_rdata_a_i[31] ^ rf_rdata_b_i[31];
      default:                 sign = rf_rdata_b_i[31];
    endcase
  end

  always_comb begin
    case (buf_op_i)
      fpu_lite_pkg::OP_FMV_W_X: result = buf_int_op_i;
      fpu_lite_pkg::OP_FMV_X_W: result = rf_rdata_a_i;
      default:                  result = {sign, rf_rdata_a_i[30:0]};
    endcase
  end

  // only FMV.X.W targets the integer register file
  assign to_int = (buf_op_i == fpu_lite_pkg::OP_FMV_X_W);

  assign rf_we_o    = fire & ~to_int;
  assign rf_waddr_o = buf_rd_i;
  assign rf_wdata_o = result;

  assign res_load_o = fire;
  assign res_id_o   = buf_id_i;
  assign res_rd_o   = buf_rd_i;
  assign res_data_o = result;
  assign res_we_o   = to_int;

endmodule

`default_nettype wire

// File: hw/fpu_lite_issue.sv
/* issue side: predecoder, accept answer and circular input buffer */

`timescale 1ns/1ps
`default_nettype none

module fpu_lite_issue #(
  parameter int IN_BUF_DEPTH = 2
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    x_issue_valid_i,
  input  fpu_lite_pkg::instr_t    x_issue_instr_i,
  input  fpu_lite_pkg::xid_t      x_issue_id_i,
  input  fpu_lite_pkg::word_t     x_issue_rs1_i,
  input  logic                    buf_pop_i,
  output logic                    x_issue_ready_o,
  output logic                    x_issue_accept_o,
  output logic                    buf_valid_o,
  output fpu_lite_pkg::op_t       buf_op_o,
  output fpu_lite_pkg::reg_addr_t buf_rd_o,
  output fpu_lite_pkg::reg_addr_t buf_rs1_o,
  output fpu_lite_pkg::reg_addr_t buf_rs2_o,
  output fpu_lite_pkg::xid_t      buf_id_o,
  output fpu_lite_pkg::word_t     buf_int_op_o
);

  localparam int PTR_W = (IN_BUF_DEPTH > 1) ? $clog2(IN_BUF_DEPTH) : 1;
  localparam int CNT_W = $clog2(IN_BUF_DEPTH + 1);

  // instruction fields
  logic [6:0]              opcode;
  logic [2:0]              funct3;
  logic [6:0]              funct7;
  fpu_lite_pkg::reg_addr_t f_rd;
  fpu_lite_pkg::reg_addr_t f_rs1;
  fpu_lite_pkg::reg_addr_t f_rs2;

  fpu_lite_pkg::op_t dec_op;
  logic              dec_ok;
  logic              push;

  // buffer storage and control
  fpu_lite_pkg::op_t       mem_op     [IN_BUF_DEPTH];
  fpu_lite_pkg::reg_addr_t mem_rd     [IN_BUF_DEPTH];
  fpu_lite_pkg::reg_addr_t mem_rs1    [IN_BUF_DEPTH];
  fpu_lite_pkg::reg_addr_t mem_rs2    [IN_BUF_DEPTH];
  fpu_lite_pkg::xid_t      mem_id     [IN_BUF_DEPTH];
  fpu_lite_pkg::word_t     mem_int_op [IN_BUF_DEPTH];
  logic [PTR_W-1:0]        wr_ptr;
  logic [PTR_W-1:0]        rd_ptr;
  logic [CNT_W-1:0]        count;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(IN_BUF_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign opcode = x_issue_instr_i[6:0];
  assign f_rd   = x_issue_instr_i[11:7];
  assign funct3 = x_issue_instr_i[14:12];
  assign f_rs1  = x_issue_instr_i[19:15];
  assign f_rs2  = x_issue_instr_i[24:20];
  assign funct7 = x_issue_instr_i[31:25];

  // predecode, accept only the five supported encodings
  always_comb begin
    dec_op = fpu_lite_pkg::OP_FSGNJ;
    dec_ok = 1'b0;
    if (opcode == fpu_lite_pkg::OPCODE_OP_FP) begin
      if (funct7 == fpu_lite_pkg::FUNCT7_FSGNJ) begin
        dec_ok = 1'b1;
        case (funct3)
          fpu_lite_pkg::FUNCT3_FSGNJ:  dec_op = fpu_lite_pkg::OP_FSGNJ;
          fpu_lite_pkg::FUNCT3_FSGNJN: dec_op = fpu_lite_pkg::OP_FSGNJN;
          fpu_lite_pkg::FUNCT3_FSGNJX: dec_op = fpu_lite_pkg::OP_FSGNJX;
          default:                     dec_ok = 1'b0;
        endcase
      end else if (funct3 == 3'b000 && f_rs2 == '0) begin
        if (funct7 == fpu_lite_pkg::FUNCT7_FMV_X_W) begin
          dec_op = fpu_lite_pkg::OP_FMV_X_W;
          dec_ok = 1'b1;
        end else if (funct7 == fpu_lite_pkg::FUNCT7_FMV_W_X) begin
          dec_op = fpu_lite_pkg::OP_FMV_W_X;
          dec_ok = 1'b1;
        end
      end
    end
  end

  assign x_issue_accept_o = dec_ok;
  // ready depends on space only, not on the accept answer
  assign x_issue_ready_o  = (count < CNT_W'(IN_BUF_DEPTH));
  assign push             = x_issue_valid_i & x_issue_ready_o & dec_ok;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_op[wr_ptr]     <= dec_op;
      mem_rd[wr_ptr]     <= f_rd;
      mem_rs1[wr_ptr]    <= f_rs1;
      mem_rs2[wr_ptr]    <= f_rs2;
      mem_id[wr_ptr]     <= x_issue_id_i;
      mem_int_op[wr_ptr] <= x_issue_rs1_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (buf_pop_i) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, buf_pop_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  // head entry
  assign buf_valid_o  = (count != '0);
  assign buf_op_o     = mem_op[rd_ptr];
  assign buf_rd_o     = mem_rd[rd_ptr];
  assign buf_rs1_o    = mem_rs1[rd_ptr];
  assign buf_rs2_o    = mem_rs2[rd_ptr];
  assign buf_id_o     = mem_id[rd_ptr];
  assign buf_int_op_o = mem_int_op[rd_ptr];

endmodule

`default_nettype wire

// File: hw/fpu_lite_pkg.sv
/* width types, decoded operation codes and RV32F encoding constants */

`default_nettype none

package fpu_lite_pkg;

  // data and control widths
  typedef logic [31:0] word_t;
  typedef logic [31:0] instr_t;
  typedef logic [3:0]  xid_t;
  typedef logic [4:0]  reg_addr_t;

  // decoded operation, one code per kept instruction
  typedef logic [2:0] op_t;

  localparam op_t OP_FSGNJ   = 3'd0;
  localparam op_t OP_FSGNJN  = 3'd1;
  localparam op_t OP_FSGNJX  = 3'd2;
  localparam op_t OP_FMV_W_X = 3'd3;
  localparam op_t OP_FMV_X_W = 3'd4;

  // major opcode of all kept instructions
  localparam logic [6:0] OPCODE_OP_FP = 7'b1010011;

  // funct7 field codes
  localparam logic [6:0] FUNCT7_FSGNJ   = 7'b0010000;
  localparam logic [6:0] FUNCT7_FMV_X_W = 7'b1110000;
  localparam logic [6:0] FUNCT7_FMV_W_X = 7'b1111000;

  // funct3 selects the sign injection variant
  localparam logic [2:0] FUNCT3_FSGNJ  = 3'b000;
  localparam logic [2:0] FUNCT3_FSGNJN = 3'b001;
  localparam logic [2:0] FUNCT3_FSGNJX = 3'b010;

endpackage

`default_nettype wire

// File: hw/fpu_lite_regfile.sv
/* floating-point register file, two read ports, one write port */

`timescale 1ns/1ps
`default_nettype none

module fpu_lite_regfile (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  fpu_lite_pkg::reg_addr_t raddr_a_i,
  input  fpu_lite_pkg::reg_addr_t raddr_b_i,
  input  logic                    we_i,
  input  fpu_lite_pkg::reg_addr_t waddr_i,
  input  fpu_lite_pkg::word_t     wdata_i,
  output fpu_lite_pkg::word_t     rdata_a_o,
  output fpu_lite_pkg::word_t     rdata_b_o
);

  fpu_lite_pkg::word_t regs [32];

  // f0 is writable like any other entry
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = regs[raddr_a_i];
  assign rdata_b_o = regs[raddr_b_i];

endmodule

`default_nettype wire

// File: hw/fpu_lite_result.sv
/* result register with valid flag, holds under back-pressure */

`timescale 1ns/1ps
`default_nettype none

module fpu_lite_result (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    res_load_i,
  input  fpu_lite_pkg::xid_t      res_id_i,
  input  fpu_lite_pkg::reg_addr_t res_rd_i,
  input  fpu_lite_pkg::word_t     res_data_i,
  input  logic                    res_we_i,
  input  logic                    x_result_ready_i,
  output logic                    res_free_o,
  output logic                    x_result_valid_o,
  output fpu_lite_pkg::xid_t      x_result_id_o,
  output fpu_lite_pkg::reg_addr_t x_result_rd_o,
  output fpu_lite_pkg::word_t     x_result_data_o,
  output logic                    x_result_we_o
);

  // free when empty or being drained this cycle
  assign res_free_o = ~x_result_valid_o | x_result_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      x_result_valid_o <= 1'b0;
    end else if (res_load_i) begin
      x_result_valid_o <= 1'b1;
    end else if (x_result_ready_i) begin
      x_result_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (res_load_i) begin
      x_result_id_o   <= res_id_i;
      x_result_rd_o   <= res_rd_i;
      x_result_data_o <= res_data_i;
      x_result_we_o   <= res_we_i;
    end
  end

endmodule

`default_nettype wire

// File: hw/fpu_lite_top.sv
/* coprocessor top level: issue, register file, exec and result */

`timescale 1ns/1ps
`default_nettype none

module fpu_lite_top #(
  parameter int IN_BUF_DEPTH = 2
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    x_issue_valid_i,
  input  fpu_lite_pkg::instr_t    x_issue_instr_i,
  input  fpu_lite_pkg::xid_t      x_issue_id_i,
  input  fpu_lite_pkg::word_t     x_issue_rs1_i,
  output logic                    x_issue_ready_o,
  output logic                    x_issue_accept_o,
  output logic                    x_result_valid_o,
  output fpu_lite_pkg::xid_t      x_result_id_o,
  output fpu_lite_pkg::reg_addr_t x_result_rd_o,
  output fpu_lite_pkg::word_t     x_result_data_o,
  output logic                    x_result_we_o,
  input  logic                    x_result_ready_i
);

  // buffer head
  logic                    buf_valid;
  logic                    buf_pop;
  fpu_lite_pkg::op_t       buf_op;
  fpu_lite_pkg::reg_addr_t buf_rd;
  fpu_lite_pkg::reg_addr_t buf_rs1;
  fpu_lite_pkg::reg_addr_t buf_rs2;
  fpu_lite_pkg::xid_t      buf_id;
  fpu_lite_pkg::word_t     buf_int_op;

  // register file ports
  fpu_lite_pkg::reg_addr_t rf_raddr_a;
  fpu_lite_pkg::reg_addr_t rf_raddr_b;
  fpu_lite_pkg::word_t     rf_rdata_a;
  fpu_lite_pkg::word_t     rf_rdata_b;
  logic                    rf_we;
  fpu_lite_pkg::reg_addr_t rf_waddr;
  fpu_lite_pkg::word_t     rf_wdata;

  // result load
  logic                    res_load;
  logic                    res_free;
  fpu_lite_pkg::xid_t      res_id;
  fpu_lite_pkg::reg_addr_t res_rd;
  fpu_lite_pkg::word_t     res_data;
  logic                    res_we;

  fpu_lite_issue #(
    .IN_BUF_DEPTH(IN_BUF_DEPTH)
  ) u_issue (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .x_issue_valid_i (x_issue_valid_i),
    .x_issue_instr_i (x_issue_instr_i),
    .x_issue_id_i    (x_issue_id_i),
    .x_issue_rs1_i   (x_issue_rs1_i),
    .buf_pop_i       (buf_pop),
    .x_issue_ready_o (x_issue_ready_o),
    .x_issue_accept_o(x_issue_accept_o),
    .buf_valid_o     (buf_valid),
    .buf_op_o        (buf_op),
    .buf_rd_o        (buf_rd),
    .buf_rs1_o       (buf_rs1),
    .buf_rs2_o       (buf_rs2),
    .buf_id_o        (buf_id),
    .buf_int_op_o    (buf_int_op)
  );

  fpu_lite_regfile u_regfile (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .raddr_a_i(rf_raddr_a),
    .raddr_b_i(rf_raddr_b),
    .we_i     (rf_we),
    .waddr_i  (rf_waddr),
    .wdata_i  (rf_wdata),
    .rdata_a_o(rf_rdata_a),
    .rdata_b_o(rf_rdata_b)
  );

  fpu_lite_exec u_exec (
    .buf_valid_i (buf_valid),
    .buf_op_i    (buf_op),
    .buf_rd_i    (buf_rd),
    .buf_rs1_i   (buf_rs1),
    .buf_rs2_i   (buf_rs2),
    .buf_id_i    (buf_id),
    .buf_int_op_i(buf_int_op),
    .res_free_i  (res_free),
    .rf_rdata_a_i(rf_rdata_a),
    .rf_rdata_b_i(rf_rdata_b),
    .buf_pop_o   (buf_pop),
    .rf_raddr_a_o(rf_raddr_a),
    .rf_raddr_b_o(rf_raddr_b),
    .rf_we_o     (rf_we),
    .rf_waddr_o  (rf_waddr),
    .rf_wdata_o  (rf_wdata),
    .res_load_o  (res_load),
    .res_id_o    (res_id),
    .res_rd_o    (res_rd),
    .res_data_o  (res_data),
    .res_we_o    (res_we)
  );

  fpu_lite_result u_result (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .res_load_i      (res_load),
    .res_id_i        (res_id),
    .res_rd_i        (res_rd),
    .res_data_i      (res_data),
    .res_we_i        (res_we),
    .x_result_ready_i(x_result_ready_i),
    .res_free_o      (res_free),
    .x_result_valid_o(x_result_valid_o),
    .x_result_id_o   (x_result_id_o),
    .x_result_rd_o   (x_result_rd_o),
    .x_result_data_o (x_result_data_o),
    .x_result_we_o   (x_result_we_o)
  );

endmodule

`default_nettype wire

// File: tests/fpu_lite_assert.sv
/* concurrent assertions on the coprocessor ports, bound to the top level */

`timescale 1ns/1ps
`default_nettype none

module fpu_lite_assert (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    issue_valid_i,
  input  logic                    issue_ready_i,
  input  logic                    result_valid_i,
  input  logic                    result_ready_i,
  input  fpu_lite_pkg::xid_t      result_id_i,
  input  fpu_lite_pkg::reg_addr_t result_rd_i,
  input  fpu_lite_pkg::word_t     result_data_i,
  input  logic                    result_we_i
);

  // set by the first issue transfer after reset
  logic issued;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      issued <= 1'b0;
    end else if (issue_valid_i && issue_ready_i) begin
      issued <= 1'b1;
    end
  end

  // stalled result must hold all its fields
  assert property (@(posedge clk_i) disable iff (rst_i)
    (result_valid_i && !result_ready_i) |=> (result_valid_i && $stable(result_id_i) &&
      $stable(result_rd_i) && $stable(result_data_i) && $stable(result_we_i)))
    else $error("result outputs changed while valid and not ready");

  assert property (@(posedge clk_i) disable iff (rst_i) !$isunknown(result_valid_i))
    else $error("result valid is unknown after reset");

  // empty buffer until something has been issued
  assert property (@(posedge clk_i) disable iff (rst_i) !issued |-> issue_ready_i)
    else $error("issue ready low before the first issue transfer");

endmodule

bind fpu_lite_top fpu_lite_assert u_assert (
  .clk_i         (clk_i),
  .rst_i         (rst_i),
  .issue_valid_i (x_issue_valid_i),
  .issue_ready_i (x_issue_ready_o),
  .result_valid_i(x_result_valid_o),
  .result_ready_i(x_result_ready_i),
  .result_id_i   (x_result_id_o),
  .result_rd_i   (x_result_rd_o),
  .result_data_i (x_result_data_o),
  .result_we_i   (x_result_we_o)
);

`default_nettype wire

// File: tests/fpu_lite_tb.sv
/* testbench for the coprocessor: stimulus table, register model,
   expected result queue, random result back-pressure */

`timescale 1ns/1ps
`default_nettype none

module fpu_lite_tb;

  localparam int          WAIT_LIMIT   = 60;
  localparam logic [31:0] SEED         = 32'hbff7;
  localparam int          READY_HIGH   = 0;
  localparam int          READY_RANDOM = 1;
  localparam int          READY_LOW    = 2;

  // RV32F encodings
  localparam logic [6:0] OPC_OP_FP  = 7'b1010011;
  localparam logic [6:0] F7_SGNJ    = 7'b0010000;
  localparam logic [6:0] F7_MV_X_W  = 7'b1110000;
  localparam logic [6:0] F7_MV_W_X  = 7'b1111000;

  typedef struct {
    int          test;
    logic [31:0] instr;
    logic [3:0]  id;
    logic [31:0] rs1;
  } row_t;

  logic        clk_i;
  logic        rst_i;
  logic        x_issue_valid_i;
  logic [31:0] x_issue_instr_i;
  logic [3:0]  x_issue_id_i;
  logic [31:0] x_issue_rs1_i;
  logic        x_issue_ready_o;
  logic        x_issue_accept_o;
  logic        x_result_valid_o;
  logic [3:0]  x_result_id_o;
  logic [4:0]  x_result_rd_o;
  logic [31:0] x_result_data_o;
  logic        x_result_we_o;
  logic        x_result_ready_i;

  row_t        table_q [$];
  logic [31:0] fregs [32];
  logic [3:0]  exp_id_q [$];
  logic [4:0]  exp_rd_q [$];
  logic [31:0] exp_data_q [$];
  logic        exp_we_q [$];
  int          errors;
  int          checks;
  int          result_count;
  int          accept_count;
  int          ready_mode;
  logic [31:0] rdy_state;
  logic [31:0] stim_state;

  fpu_lite_top #(
    .IN_BUF_DEPTH(2)
  ) UUT (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .x_issue_valid_i (x_issue_valid_i),
    .x_issue_instr_i (x_issue_instr_i),
    .x_issue_id_i    (x_issue_id_i),
    .x_issue_rs1_i   (x_issue_rs1_i),
    .x_issue_ready_o (x_issue_ready_o),
    .x_issue_accept_o(x_issue_accept_o),
    .x_result_valid_o(x_result_valid_o),
    .x_result_id_o   (x_result_id_o),
    .x_result_rd_o   (x_result_rd_o),
    .x_result_data_o (x_result_data_o),
    .x_result_we_o   (x_result_we_o),
    .x_result_ready_i(x_result_ready_i)
  );

  always #50 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] enc_sgnj(input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [4:0] a, input logic [4:0] b);
    return {F7_SGNJ, b, a, f3, rd, OPC_OP_FP};
  endfunction

  function automatic logic [31:0] enc_mv_w_x(input logic [4:0] rd);
    return {F7_MV_W_X, 5'd0, 5'd10, 3'b000, rd, OPC_OP_FP};
  endfunction

  function automatic logic [31:0] enc_mv_x_w(input logic [4:0] rd, input logic [4:0] a);
    return {F7_MV_X_W, 5'd0, a, 3'b000, rd, OPC_OP_FP};
  endfunction

  function automatic string test_name(input int num);
    case (num)
      1:       return "reset state";
      2:       return "fmv round trip";
      3:       return "sign injection";
      4:       return "rejected instructions";
      5:       return "random back-pressure";
      default: return "result latency";
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  task automatic add_row(input int test, input logic [31:0] instr, input logic [3:0] id,
                         input logic [31:0] rs1);
    row_t r;
    r.test  = test;
    r.instr = instr;
    r.id    = id;
    r.rs1   = rs1;
    table_q.push_back(r);
  endtask

  // reference model, updated in issue order
  task automatic model_instr(input logic [31:0] instr, input logic [3:0] id,
                             input logic [31:0] rs1, output logic acc);
    logic [4:0]  rd;
    logic [4:0]  a;
    logic [4:0]  b;
    logic [2:0]  f3;
    logic [31:0] data;
    logic        sgn;
    logic        we;
    rd   = instr[11:7];
    f3   = instr[14:12];
    a    = instr[19:15];
    b    = instr[24:20];
    acc  = 1'b0;
    we   = 1'b0;
    data = '0;
    if (instr[6:0] == OPC_OP_FP && instr[31:25] == F7_SGNJ && f3 <= 3'b010) begin
      acc = 1'b1;
      case (f3)
        3'b000:  sgn = fregs[b][31];
        3'b001:  sgn = ~fregs[b][31];
        default: sgn = fregs[a][31] ^ fregs[b][31];
      endcase
      data      = {sgn, fregs[a][30:0]};
      fregs[rd] = data;
    end else if (instr[6:0] == OPC_OP_FP && instr[31:25] == F7_MV_W_X &&
                 f3 == 3'b000 && b == 5'd0) begin
      acc       = 1'b1;
      data      = rs1;
      fregs[rd] = data;
    end else if (instr[6:0] == OPC_OP_FP && instr[31:25] == F7_MV_X_W &&
                 f3 == 3'b000 && b == 5'd0) begin
      acc  = 1'b1;
      data = fregs[a];
      we   = 1'b1;
    end
    if (acc) begin
      exp_id_q.push_back(id);
      exp_rd_q.push_back(rd);
      exp_data_q.push_back(data);
      exp_we_q.push_back(we);
      accept_count++;
    end
  endtask

  // entered and left a short delay after a rising edge
  task automatic issue_instr(input logic [31:0] instr, input logic [3:0] id,
                             input logic [31:0] rs1);
    int   n;
    logic acc;
    x_issue_valid_i = 1'b1;
    x_issue_instr_i = instr;
    x_issue_id_i    = id;
    x_issue_rs1_i   = rs1;
    n = 0;
    @(negedge clk_i);
    while (!x_issue_ready_o && n < WAIT_LIMIT) begin
      @(negedge clk_i);
      n++;
    end
    if (!x_issue_ready_o) begin
      $display("timeout: issue ready stayed low for instruction id 0x%h", id);
      errors++;
    end else begin
      model_instr(instr, id, rs1, acc);
      check_value("x_issue_accept_o", x_issue_accept_o, acc);
    end
    @(posedge clk_i);
    #1;
    x_issue_valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_data_q.size() != 0 && n < WAIT_LIMIT) begin
      @(posedge clk_i);
      #1;
      n++;
    end
    if (exp_data_q.size() != 0) begin
      $display("timeout: %0d results never arrived", exp_data_q.size());
      errors++;
      exp_id_q.delete();
      exp_rd_q.delete();
      exp_data_q.delete();
      exp_we_q.delete();
    end
  endtask

  task automatic report_test(input int num, input int err_start);
    $display("test %0d %s: %0d errors", num, test_name(num), errors - err_start);
  endtask

  task automatic run_table(input int first_start);
    int cur;
    int start;
    cur   = table_q[0].test;
    start = first_start;
    foreach (table_q[i]) begin
      if (table_q[i].test != cur) begin
        wait_drain();
        check_value("result count", result_count, accept_count);
        report_test(cur, start);
        cur   = table_q[i].test;
        start = errors;
      end
      issue_instr(table_q[i].instr, table_q[i].id, table_q[i].rs1);
    end
    wait_drain();
    check_value("result count", result_count, accept_count);
    report_test(cur, start);
  endtask

  // result ready driver
  always @(posedge clk_i) begin
    #1;
    case (ready_mode)
      READY_RANDOM: begin
        rdy_state        = xorshift(rdy_state);
        x_result_ready_i = (rdy_state[1:0] != 2'b00);
      end
      READY_LOW: x_result_ready_i = 1'b0;
      default:   x_result_ready_i = 1'b1;
    endcase
  end

  // result monitor, compares in issue order
  always @(negedge clk_i) begin
    if (!rst_i && x_result_valid_o && x_result_ready_i) begin
      result_count++;
      if (exp_data_q.size() == 0) begin
        $display("unexpected result with id 0x%h while nothing was outstanding",
                 x_result_id_o);
        errors++;
      end else begin
        check_value("x_result_id_o", x_result_id_o, exp_id_q.pop_front());
        check_value("x_result_rd_o", x_result_rd_o, exp_rd_q.pop_front());
        check_value("x_result_data_o", x_result_data_o, exp_data_q.pop_front());
        check_value("x_result_we_o", x_result_we_o, exp_we_q.pop_front());
      end
    end
  end

  initial begin
    int          start;
    int          n;
    int          edges;
    logic        fell;
    logic        acc;
    logic [31:0] r;
    logic [31:0] instr;
    clk_i            = 1'b0;
    rst_i            = 1'b1;
    x_issue_valid_i  = 1'b0;
    x_issue_instr_i  = '0;
    x_issue_id_i     = '0;
    x_issue_rs1_i    = '0;
    x_result_ready_i = 1'b1;
    ready_mode       = READY_HIGH;
    rdy_state        = SEED;
    stim_state       = xorshift(SEED);
    errors           = 0;
    checks           = 0;
    result_count     = 0;
    accept_count     = 0;
    for (int i = 0; i < 32; i++) begin
      fregs[i] = '0;
    end

    // reads of untouched registers
    add_row(1, enc_mv_x_w(5'd1, 5'd0), 4'h1, 32'h0);
    add_row(1, enc_mv_x_w(5'd2, 5'd7), 4'h2, 32'h0);
    add_row(1, enc_mv_x_w(5'd3, 5'd31), 4'h3, 32'h0);
    add_row(2, enc_mv_w_x(5'd1), 4'h4, 32'h3f800000);
    add_row(2, enc_mv_w_x(5'd2), 4'h5, 32'hc0490fdb);
    add_row(2, enc_mv_w_x(5'd31), 4'h6, 32'h7f7fffff);
    add_row(2, enc_mv_w_x(5'd0), 4'h7, 32'h80000001);
    add_row(2, enc_mv_x_w(5'd5, 5'd1), 4'h8, 32'h0);
    add_row(2, enc_mv_x_w(5'd6, 5'd2), 4'h9, 32'h0);
    add_row(2, enc_mv_x_w(5'd7, 5'd31), 4'ha, 32'h0);
    add_row(2, enc_mv_x_w(5'd8, 5'd0), 4'hb, 32'h0);
    add_row(3, enc_sgnj(3'b000, 5'd10, 5'd1, 5'd2), 4'hc, 32'h0);
    add_row(3, enc_sgnj(3'b001, 5'd11, 5'd2, 5'd1), 4'hd, 32'h0);
    add_row(3, enc_sgnj(3'b010, 5'd12, 5'd2, 5'd0), 4'he, 32'h0);
    add_row(3, enc_sgnj(3'b000, 5'd13, 5'd31, 5'd31), 4'hf, 32'h0);
    add_row(3, enc_mv_x_w(5'd20, 5'd10), 4'h0, 32'h0);
    add_row(3, enc_mv_x_w(5'd21, 5'd11), 4'h1, 32'h0);
    add_row(3, enc_mv_x_w(5'd22, 5'd12), 4'h2, 32'h0);
    add_row(3, enc_mv_x_w(5'd23, 5'd13), 4'h3, 32'h0);
    // wrong opcode, funct3 011, nonzero rs2 on both moves
    add_row(4, {F7_SGNJ, 5'd2, 5'd1, 3'b000, 5'd14, 7'b1000011}, 4'h4, 32'h0);
    add_row(4, enc_sgnj(3'b011, 5'd14, 5'd1, 5'd2), 4'h5, 32'h0);
    add_row(4, enc_mv_x_w(5'd24, 5'd1), 4'h6, 32'h0);
    add_row(4, {F7_MV_X_W, 5'd1, 5'd1, 3'b000, 5'd15, OPC_OP_FP}, 4'h7, 32'h0);
    add_row(4, {F7_MV_W_X, 5'd3, 5'd10, 3'b000, 5'd1, OPC_OP_FP}, 4'h8, 32'h12345678);
    add_row(4, enc_mv_x_w(5'd25, 5'd1), 4'h9, 32'h0);

    repeat (8) @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    start = errors;
    @(negedge clk_i);
    check_value("x_result_valid_o", x_result_valid_o, 1'b0);
    check_value("x_issue_ready_o", x_issue_ready_o, 1'b1);
    @(posedge clk_i);
    #1;
    run_table(start);

    // random mix, then hold ready low until the buffer fills
    start      = errors;
    ready_mode = READY_RANDOM;
    for (int i = 0; i < 24; i++) begin
      stim_state = xorshift(stim_state);
      r          = stim_state;
      case (r[1:0])
        2'd0:    instr = enc_mv_w_x(r[6:2]);
        2'd1:    instr = enc_mv_x_w(r[6:2], r[11:7]);
        2'd2:    instr = enc_sgnj({1'b0, r[13:12]}, r[6:2], r[11:7], r[18:14]);
        default: instr = enc_sgnj(3'b010, r[6:2], r[11:7], r[18:14]);
      endcase
      stim_state = xorshift(stim_state);
      issue_instr(instr, i[3:0], stim_state);
    end
    ready_mode = READY_LOW;
    fell       = 1'b0;
    n          = 0;
    while (!fell && n < 16) begin
      if (!x_issue_ready_o) begin
        fell = 1'b1;
      end else begin
        stim_state = xorshift(stim_state);
        issue_instr(enc_mv_w_x(5'd9), n[3:0], stim_state);
        n++;
      end
    end
    if (!fell) begin
      $display("issue ready never fell while result ready was held low");
      errors++;
    end
    ready_mode = READY_RANDOM;
    wait_drain();
    check_value("result count", result_count, accept_count);
    report_test(5, start);

    // the transfer edge counts as the first of the two
    start      = errors;
    ready_mode = READY_HIGH;
    repeat (2) @(posedge clk_i);
    #1;
    x_issue_valid_i = 1'b1;
    x_issue_instr_i = enc_mv_x_w(5'd3, 5'd1);
    x_issue_id_i    = 4'h6;
    x_issue_rs1_i   = '0;
    n = 0;
    @(negedge clk_i);
    while (!x_issue_ready_o && n < WAIT_LIMIT) begin
      @(negedge clk_i);
      n++;
    end
    if (!x_issue_ready_o) begin
      $display("timeout: issue ready stayed low before the single issue");
      errors++;
    end else begin
      model_instr(x_issue_instr_i, x_issue_id_i, x_issue_rs1_i, acc);
      check_value("x_issue_accept_o", x_issue_accept_o, acc);
    end
    @(posedge clk_i);
    edges = 1;
    #1;
    x_issue_valid_i = 1'b0;
    @(negedge clk_i);
    while (!x_result_valid_o && edges < WAIT_LIMIT) begin
      @(posedge clk_i);
      edges++;
      @(negedge clk_i);
    end
    if (!x_result_valid_o) begin
      $display("timeout: result valid never rose after a single issue");
      errors++;
    end
    check_value("result latency edges", edges, 2);
    @(posedge clk_i);
    #1;
    wait_drain();
    report_test(6, start);

    $display("tests 6, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire
